//--- logic/riscvDecode_consts.svh
`ifndef RISCVDECODE_CONSTS_SVH
`define RISCVDECODE_CONSTS_SVH

// field and control widths
`define INSTR_W     32
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7
`define REG_W       5
`define ALUOP_W     5
`define SEL_W       3
`define CSRKIND_W   2
`define CAUSE_W     32

// RV32IM opcodes
`define OPC_LOAD    7'b0000011
`define OPC_OPIMM   7'b0010011
`define OPC_AUIPC   7'b0010111
`define OPC_STORE   7'b0100011
`define OPC_RTYPE   7'b0110011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JALR    7'b1100111
`define OPC_JAL     7'b1101111
`define OPC_SYSTEM  7'b1110011

// integer arithmetic funct3
`define FUNCT3_ADD    3'b000
`define FUNCT3_SLL    3'b001
`define FUNCT3_SLT    3'b010
`define FUNCT3_SLTU   3'b011
`define FUNCT3_XOR    3'b100
`define FUNCT3_SRL    3'b101
`define FUNCT3_OR     3'b110
`define FUNCT3_AND    3'b111

// M extension funct3
`define FUNCT3_MUL    3'b000
`define FUNCT3_MULH   3'b001
`define FUNCT3_MULHSU 3'b010
`define FUNCT3_MULHU  3'b011
`define FUNCT3_DIV    3'b100
`define FUNCT3_DIVU   3'b101
`define FUNCT3_REM    3'b110
`define FUNCT3_REMU   3'b111

// SYSTEM funct3
`define FUNCT3_ECALL  3'b000
`define FUNCT3_CSRRW  3'b001
`define FUNCT3_CSRRS  3'b010
`define FUNCT3_CSRRC  3'b011
`define FUNCT3_CSRRWI 3'b101
`define FUNCT3_CSRRSI 3'b110
`define FUNCT3_CSRRCI 3'b111

`define FUNCT7_ZERO   7'b0000000
`define FUNCT7_SUB    7'b0100000 // also marks SRA / SRAI
`define FUNCT7_MULDIV 7'b0000001

`define RS2_ECALL     5'b00000
`define RS2_URET      5'b00010

// ALU operation codes
`define OPADD     5'd0
`define OPSUB     5'd1
`define OPSLL     5'd2
`define OPSLT     5'd3
`define OPSLTU    5'd4
`define OPXOR     5'd5
`define OPSRL     5'd6
`define OPSRA     5'd7
`define OPOR      5'd8
`define OPAND     5'd9
`define OPMUL     5'd10
`define OPMULH    5'd11
`define OPMULHSU  5'd12
`define OPMULHU   5'd13
`define OPDIV     5'd14
`define OPDIVU    5'd15
`define OPREM     5'd16
`define OPREMU    5'd17
`define OPLUI     5'd18
`define OPNULL    5'd31

// next PC source
`define PC_PLUS4  3'd0
`define PC_BRANCH 3'd1
`define PC_JAL    3'd2
`define PC_JALR   3'd3
`define PC_VECTOR 3'd4 // utvec on trap, uepc on uret

// register write-back source
`define REGSRC_ALU 3'd0
`define REGSRC_PC4 3'd1
`define REGSRC_MEM 3'd2
`define REGSRC_CSR 3'd4

// CSR write-data source
`define CSRSRC_REG    3'd0
`define CSRSRC_ORREG  3'd1
`define CSRSRC_CLRREG 3'd2
`define CSRSRC_IMM    3'd3
`define CSRSRC_ORIMM  3'd4
`define CSRSRC_CLRIMM 3'd5
`define CSRSRC_INSTR  3'd6

`define CSRKIND_NONE 2'd0
`define CSRKIND_EXC  2'd1
`define CSRKIND_URET 2'd2
`define CSRKIND_CSR  2'd3

`define CAUSE_ILLEGAL 32'd2
`define CAUSE_ECALL   32'd8

`endif

//--- logic/decodeTypes.sv
`include "riscvDecode_consts.svh"

package decodeTypes;

	// raw instruction and its fields
	typedef logic [`INSTR_W-1:0] instrWord;
	typedef logic [`OPCODE_W-1:0] opcodeField;
	typedef logic [`FUNCT3_W-1:0] funct3Field;
	typedef logic [`FUNCT7_W-1:0] funct7Field;
	typedef logic [`REG_W-1:0] regAddr; // rs1, rs2 or rd index

	// ALU operation handed to the execute stage
	typedef logic [`ALUOP_W-1:0] aluOp;

	// next PC source, see PC_ defines
	typedef logic [`SEL_W-1:0] pcSel;

	// write-back mux select, see REGSRC_ defines
	typedef logic [`SEL_W-1:0] regSrcSel;

	// CSR write data, see CSRSRC_ defines
	typedef logic [`SEL_W-1:0] csrSrcSel;

	// kind of CSR-file access: none, exception, uret, CSR op
	typedef logic [`CSRKIND_W-1:0] csrKind;

	// value written to ucause
	typedef logic [`CAUSE_W-1:0] causeWord;

endpackage

//--- logic/aluOpDecoder.sv
`timescale 1ns/100ps
`include "riscvDecode_consts.svh"

module aluOpDecoder
(
	input decodeTypes::instrWord instr,
	output decodeTypes::aluOp aluControl,
	output logic aluIllegal
);

	import decodeTypes::*;

	funct3Field funct3;
	funct7Field funct7;
	logic regForm; // OP rather than OP-IMM
	logic altForm; // sub / arithmetic shift marker

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign regForm = instr[5]; // only bit 5 differs between the two opcodes
	assign altForm = (funct7 == `FUNCT7_SUB);

	always_comb
	begin
		aluControl = `OPNULL;
		aluIllegal = 1'b0;
		if (regForm && funct7 == `FUNCT7_MULDIV)
		begin
			case (funct3)
				`FUNCT3_MUL:    aluControl = `OPMUL;
				`FUNCT3_MULH:   aluControl = `OPMULH;
				`FUNCT3_MULHSU: aluControl = `OPMULHSU;
				`FUNCT3_MULHU:  aluControl = `OPMULHU;
				`FUNCT3_DIV:    aluControl = `OPDIV;
				`FUNCT3_DIVU:   aluControl = `OPDIVU;
				`FUNCT3_REM:    aluControl = `OPREM;
				`FUNCT3_REMU:   aluControl = `OPREMU;
				default:        aluControl = `OPNULL;
			endcase
		end
		else if (regForm && funct7 != `FUNCT7_ZERO && !altForm)
			aluIllegal = 1'b1; // unknown funct7 in register form
		else
		begin
			case (funct3)
				// addi has no subtract form, its upper bits are immediate
				`FUNCT3_ADD:  aluControl = (regForm && altForm) ? `OPSUB : `OPADD;
				`FUNCT3_SLL:  aluControl = `OPSLL;
				`FUNCT3_SLT:  aluControl = `OPSLT;
				`FUNCT3_SLTU: aluControl = `OPSLTU;
				`FUNCT3_XOR:  aluControl = `OPXOR;
				`FUNCT3_SRL:  aluControl = altForm ? `OPSRA : `OPSRL; // same rule for srai
				`FUNCT3_OR:   aluControl = `OPOR;
				`FUNCT3_AND:  aluControl = `OPAND;
				default:      aluControl = `OPNULL;
			endcase
		end
	end

endmodule

//--- logic/systemDecoder.sv
`timescale 1ns/100ps
`include "riscvDecode_consts.svh"

module systemDecoder
(
	input decodeTypes::instrWord instr,
	output logic regWrite,
	output logic csrWrite,
	output logic causeWrite,
	output logic epcWrite,
	output logic sysIllegal,
	output decodeTypes::csrSrcSel csrSource,
	output decodeTypes::csrKind csrKind,
	output decodeTypes::causeWord causeData,
	output decodeTypes::pcSel pcSource
);

	import decodeTypes::*;

	funct3Field funct3;
	regAddr rs2; // tells ecall from uret

	assign funct3 = instr[14:12];
	assign rs2 = instr[24:20];

	always_comb
	begin
		regWrite = 1'b0;
		csrWrite = 1'b0;
		causeWrite = 1'b0;
		epcWrite = 1'b0;
		sysIllegal = 1'b0;
		csrSource = `CSRSRC_REG;
		csrKind = `CSRKIND_NONE;
		causeData = '0;
		pcSource = `PC_PLUS4;
		case (funct3)
			`FUNCT3_ECALL:
			begin
				if (rs2 == `RS2_ECALL)
				begin
					causeWrite = 1'b1;
					causeData = `CAUSE_ECALL;
					epcWrite = 1'b1; // save pc of the ecall
					csrKind = `CSRKIND_EXC;
					pcSource = `PC_VECTOR;
				end
				else if (rs2 == `RS2_URET)
				begin
					csrKind = `CSRKIND_URET;
					pcSource = `PC_VECTOR; // back to uepc
				end
				else
					sysIllegal = 1'b1;
			end
			`FUNCT3_CSRRW,
			`FUNCT3_CSRRS,
			`FUNCT3_CSRRC,
			`FUNCT3_CSRRWI,
			`FUNCT3_CSRRSI,
			`FUNCT3_CSRRCI:
			begin
				regWrite = 1'b1; // old csr value to rd
				csrWrite = 1'b1;
				csrKind = `CSRKIND_CSR;
				case (funct3)
					`FUNCT3_CSRRS:  csrSource = `CSRSRC_ORREG;
					`FUNCT3_CSRRC:  csrSource = `CSRSRC_CLRREG;
					`FUNCT3_CSRRWI: csrSource = `CSRSRC_IMM;
					`FUNCT3_CSRRSI: csrSource = `CSRSRC_ORIMM;
					`FUNCT3_CSRRCI: csrSource = `CSRSRC_CLRIMM;
					default:        csrSource = `CSRSRC_REG;
				endcase
			end
			default: sysIllegal = 1'b1; // funct3 4 is reserved
		endcase
	end

endmodule

//--- logic/opcodeDecoder.sv
`timescale 1ns/100ps
`include "riscvDecode_consts.svh"

module opcodeDecoder
(
	input decodeTypes::instrWord instr,
	input decodeTypes::aluOp aluControlIn,
	input logic aluIllegal,
	input logic sysRegWrite,
	input logic sysCsrWrite,
	input logic sysCauseWrite,
	input logic sysEpcWrite,
	input logic sysIllegal,
	input decodeTypes::csrSrcSel sysCsrSource,
	input decodeTypes::csrKind sysCsrKind,
	input decodeTypes::causeWord sysCauseData,
	input decodeTypes::pcSel sysPcSource,
	output logic aluSrcA,
	output logic aluSrcB,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output decodeTypes::regSrcSel regSrc,
	output decodeTypes::pcSel pcSource,
	output decodeTypes::aluOp aluControl,
	output logic csrWrite,
	output logic causeWrite,
	output logic epcWrite,
	output decodeTypes::csrSrcSel csrSource,
	output decodeTypes::csrKind csrKind,
	output decodeTypes::causeWord causeData
);

	import decodeTypes::*;

	opcodeField opcode;
	logic illegal; // any decoder rejected the word

	assign opcode = instr[6:0];

	always_comb
	begin
		aluSrcA = 1'b0;
		aluSrcB = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		regSrc = `REGSRC_ALU;
		pcSource = `PC_PLUS4;
		aluControl = `OPADD;
		csrWrite = 1'b0;
		causeWrite = 1'b0;
		epcWrite = 1'b0;
		csrSource = `CSRSRC_REG;
		csrKind = `CSRKIND_NONE;
		causeData = '0;
		illegal = 1'b0;
		case (opcode)
			`OPC_LOAD:
			begin
				aluSrcB = 1'b1; // base + offset
				regWrite = 1'b1;
				memRead = 1'b1;
				regSrc = `REGSRC_MEM;
			end
			`OPC_STORE:
			begin
				aluSrcB = 1'b1;
				memWrite = 1'b1;
			end
			`OPC_OPIMM:
			begin
				aluSrcB = 1'b1;
				regWrite = 1'b1;
				aluControl = aluControlIn;
			end
			`OPC_RTYPE:
			begin
				regWrite = 1'b1;
				aluControl = aluControlIn;
				illegal = aluIllegal;
			end
			`OPC_AUIPC:
			begin
				aluSrcA = 1'b1; // pc as operand a
				aluSrcB = 1'b1;
				regWrite = 1'b1;
			end
			`OPC_LUI:
			begin
				aluSrcB = 1'b1;
				regWrite = 1'b1;
				aluControl = `OPLUI;
			end
			`OPC_BRANCH: pcSource = `PC_BRANCH;
			`OPC_JALR:
			begin
				regWrite = 1'b1;
				regSrc = `REGSRC_PC4; // link address
				pcSource = `PC_JALR;
			end
			`OPC_JAL:
			begin
				regWrite = 1'b1;
				regSrc = `REGSRC_PC4;
				pcSource = `PC_JAL;
			end
			`OPC_SYSTEM:
			begin
				regWrite = sysRegWrite;
				regSrc = sysRegWrite ? `REGSRC_CSR : `REGSRC_ALU;
				pcSource = sysPcSource;
				csrWrite = sysCsrWrite;
				causeWrite = sysCauseWrite;
				epcWrite = sysEpcWrite;
				csrSource = sysCsrSource;
				csrKind = sysCsrKind;
				causeData = sysCauseData;
				illegal = sysIllegal;
			end
			default: illegal = 1'b1; // unknown opcode
		endcase

		// illegal instruction trap overrides everything above
		if (illegal)
		begin
			aluSrcA = 1'b0;
			aluSrcB = 1'b0;
			regWrite = 1'b0;
			memWrite = 1'b0;
			memRead = 1'b0;
			regSrc = `REGSRC_ALU;
			aluControl = `OPNULL;
			csrWrite = 1'b1;
			csrSource = `CSRSRC_INSTR; // faulting word into utval
			causeWrite = 1'b1;
			causeData = `CAUSE_ILLEGAL;
			epcWrite = 1'b1;
			csrKind = `CSRKIND_EXC;
			pcSource = `PC_VECTOR; // jump to utvec
		end
	end

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/100ps
`include "riscvDecode_consts.svh"

module controlUnit
(
	input logic iCLK,
	input logic reset,
	input decodeTypes::instrWord instr,
	input logic instrValid,
	output logic aluSrcA,
	output logic aluSrcB,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output decodeTypes::regSrcSel regSrc,
	output decodeTypes::pcSel pcSource,
	output decodeTypes::aluOp aluControl,
	output logic csrWrite,
	output logic causeWrite,
	output logic epcWrite,
	output decodeTypes::csrSrcSel csrSource,
	output decodeTypes::csrKind csrKind,
	output decodeTypes::causeWord causeData,
	output logic decodeValid
);

	import decodeTypes::*;

	aluOp aluControlNext; // from the arithmetic decoder
	logic aluIllegal;

	logic sysRegWrite;
	logic sysCsrWrite;
	logic sysCauseWrite;
	logic sysEpcWrite;
	logic sysIllegal;
	csrSrcSel sysCsrSource;
	decodeTypes::csrKind sysCsrKind; // port csrKind hides the type name
	causeWord sysCauseData;
	pcSel sysPcSource;

	// complete combinational control set
	logic decAluSrcA;
	logic decAluSrcB;
	logic decRegWrite;
	logic decMemWrite;
	logic decMemRead;
	regSrcSel decRegSrc;
	pcSel decPcSource;
	aluOp decAluControl;
	logic decCsrWrite;
	logic decCauseWrite;
	logic decEpcWrite;
	csrSrcSel decCsrSource;
	decodeTypes::csrKind decCsrKind;
	causeWord decCauseData;

	aluOpDecoder aluDec
	(
		.instr(instr),
		.aluControl(aluControlNext),
		.aluIllegal(aluIllegal)
	);

	systemDecoder sysDec
	(
		.instr(instr),
		.regWrite(sysRegWrite),
		.csrWrite(sysCsrWrite),
		.causeWrite(sysCauseWrite),
		.epcWrite(sysEpcWrite),
		.sysIllegal(sysIllegal),
		.csrSource(sysCsrSource),
		.csrKind(sysCsrKind),
		.causeData(sysCauseData),
		.pcSource(sysPcSource)
	);

	opcodeDecoder opcDec
	(
		.instr(instr),
		.aluControlIn(aluControlNext),
		.aluIllegal(aluIllegal),
		.sysRegWrite(sysRegWrite),
		.sysCsrWrite(sysCsrWrite),
		.sysCauseWrite(sysCauseWrite),
		.sysEpcWrite(sysEpcWrite),
		.sysIllegal(sysIllegal),
		.sysCsrSource(sysCsrSource),
		.sysCsrKind(sysCsrKind),
		.sysCauseData(sysCauseData),
		.sysPcSource(sysPcSource),
		.aluSrcA(decAluSrcA),
		.aluSrcB(decAluSrcB),
		.regWrite(decRegWrite),
		.memWrite(decMemWrite),
		.memRead(decMemRead),
		.regSrc(decRegSrc),
		.pcSource(decPcSource),
		.aluControl(decAluControl),
		.csrWrite(decCsrWrite),
		.causeWrite(decCauseWrite),
		.epcWrite(decEpcWrite),
		.csrSource(decCsrSource),
		.csrKind(decCsrKind),
		.causeData(decCauseData)
	);

	// decode register, idle cycles load the inactive set
	always_ff @(posedge iCLK)
	begin
		if (reset || !instrValid)
		begin
			decodeValid <= 1'b0;
			aluSrcA <= 1'b0;
			aluSrcB <= 1'b0;
			regWrite <= 1'b0;
			memWrite <= 1'b0;
			memRead <= 1'b0;
			regSrc <= '0;
			pcSource <= '0;
			aluControl <= '0;
			csrWrite <= 1'b0;
			causeWrite <= 1'b0;
			epcWrite <= 1'b0;
			csrSource <= '0;
			csrKind <= '0;
			causeData <= '0;
		end
		else
		begin
			decodeValid <= 1'b1; // one cycle per accepted word
			aluSrcA <= decAluSrcA;
			aluSrcB <= decAluSrcB;
			regWrite <= decRegWrite;
			memWrite <= decMemWrite;
			memRead <= decMemRead;
			regSrc <= decRegSrc;
			pcSource <= decPcSource;
			aluControl <= decAluControl;
			csrWrite <= decCsrWrite;
			causeWrite <= decCauseWrite;
			epcWrite <= decEpcWrite;
			csrSource <= decCsrSource;
			csrKind <= decCsrKind;
			causeData <= decCauseData;
		end
	end

endmodule

//--- tests/controlUnit_assert.sv
`timescale 1ns/100ps
`include "riscvDecode_consts.svh"

module controlUnit_assert
(
	input logic iCLK,
	input logic reset,
	input logic decodeValid,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	input logic csrWrite,
	input logic causeWrite,
	input logic epcWrite,
	input decodeTypes::pcSel pcSource
);

	import decodeTypes::*;

	memExclusive: assert property (@(posedge iCLK) disable iff (reset)
		!(memRead && memWrite))
		else $error("memRead and memWrite high together");

	// a trap always saves the pc and jumps to the vector
	trapComplete: assert property (@(posedge iCLK) disable iff (reset)
		causeWrite |-> (epcWrite && pcSource == `PC_VECTOR))
		else $error("causeWrite without epcWrite or vector pc");

	idleQuiet: assert property (@(posedge iCLK) disable iff (reset)
		!decodeValid |-> !(regWrite || memRead || memWrite || csrWrite || causeWrite || epcWrite))
		else $error("enable high while decodeValid is low");

endmodule

//--- tests/controlUnitTb.sv
`timescale 1ns/100ps
`include "riscvDecode_consts.svh"

module controlUnitTb;

	import decodeTypes::*;

	localparam int TIMEOUT_CYCLES = 3000; // tests need about 500 cycles

	logic iCLK;
	logic reset;
	instrWord instr;
	logic instrValid;
	logic aluSrcA;
	logic aluSrcB;
	logic regWrite;
	logic memWrite;
	logic memRead;
	regSrcSel regSrc;
	pcSel pcSource;
	aluOp aluControl;
	logic csrWrite;
	logic causeWrite;
	logic epcWrite;
	csrSrcSel csrSource;
	csrKind csrKindOut;
	causeWord causeData;
	logic decodeValid;

	// expected set for the word driven at the previous falling edge
	instrWord expInstr;
	logic expDecodeValid;
	logic expAluSrcA;
	logic expAluSrcB;
	logic expRegWrite;
	logic expMemWrite;
	logic expMemRead;
	regSrcSel expRegSrc;
	pcSel expPcSource;
	aluOp expAluControl;
	logic expCsrWrite;
	logic expCauseWrite;
	logic expEpcWrite;
	csrSrcSel expCsrSource;
	csrKind expCsrKind;
	causeWord expCauseData;

	int cycles = 0;

	controlUnit dut
	(
		.iCLK(iCLK),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.memRead(memRead),
		.regSrc(regSrc),
		.pcSource(pcSource),
		.aluControl(aluControl),
		.csrWrite(csrWrite),
		.causeWrite(causeWrite),
		.epcWrite(epcWrite),
		.csrSource(csrSource),
		.csrKind(csrKindOut),
		.causeData(causeData),
		.decodeValid(decodeValid)
	);

	bind controlUnit controlUnit_assert checks
	(
		.iCLK(iCLK),
		.reset(reset),
		.decodeValid(decodeValid),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.csrWrite(csrWrite),
		.causeWrite(causeWrite),
		.epcWrite(epcWrite),
		.pcSource(pcSource)
	);

	initial iCLK = 1'b0;
	always #10 iCLK = ~iCLK; // 20 ns period

	always @(posedge iCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERR %s got 0x%0h expected 0x%0h for instr 0x%08h", name, got, exp, expInstr);
		$display("TESTBENCH FAILED");
		$fatal(1, "decode output %s is wrong", name);
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkAluOp(input string name, input aluOp got, input aluOp exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkPcSel(input string name, input pcSel got, input pcSel exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkRegSrc(input string name, input regSrcSel got, input regSrcSel exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkCsrSrc(input string name, input csrSrcSel got, input csrSrcSel exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkCsrKind(input string name, input csrKind got, input csrKind exp);
		if (got !== exp)
			reportMismatch(name, 32'(got), 32'(exp));
	endtask

	task automatic checkCause(input string name, input causeWord got, input causeWord exp);
		if (got !== exp)
			reportMismatch(name, got, exp);
	endtask

	task automatic checkOutputs();
		checkBit("decodeValid", decodeValid, expDecodeValid);
		checkBit("aluSrcA", aluSrcA, expAluSrcA);
		checkBit("aluSrcB", aluSrcB, expAluSrcB);
		checkBit("regWrite", regWrite, expRegWrite);
		checkBit("memWrite", memWrite, expMemWrite);
		checkBit("memRead", memRead, expMemRead);
		checkRegSrc("regSrc", regSrc, expRegSrc);
		checkPcSel("pcSource", pcSource, expPcSource);
		checkAluOp("aluControl", aluControl, expAluControl);
		checkBit("csrWrite", csrWrite, expCsrWrite);
		checkBit("causeWrite", causeWrite, expCauseWrite);
		checkBit("epcWrite", epcWrite, expEpcWrite);
		checkCsrSrc("csrSource", csrSource, expCsrSource);
		checkCsrKind("csrKind", csrKindOut, expCsrKind);
		checkCause("causeData", causeData, expCauseData);
	endtask

	task automatic clearExpected();
		expDecodeValid = 1'b0;
		expAluSrcA = 1'b0;
		expAluSrcB = 1'b0;
		expRegWrite = 1'b0;
		expMemWrite = 1'b0;
		expMemRead = 1'b0;
		expRegSrc = `REGSRC_ALU;
		expPcSource = `PC_PLUS4;
		expAluControl = `OPADD;
		expCsrWrite = 1'b0;
		expCauseWrite = 1'b0;
		expEpcWrite = 1'b0;
		expCsrSource = `CSRSRC_REG;
		expCsrKind = `CSRKIND_NONE;
		expCauseData = '0;
	endtask

	// base integer op, alt is funct7 == 0100000
	function automatic aluOp baseAluOp(input funct3Field f3, input logic alt, input logic isReg);
		case (f3)
			3'd0: return (alt && isReg) ? `OPSUB : `OPADD;
			3'd1: return `OPSLL;
			3'd2: return `OPSLT;
			3'd3: return `OPSLTU;
			3'd4: return `OPXOR;
			3'd5: return alt ? `OPSRA : `OPSRL;
			3'd6: return `OPOR;
			default: return `OPAND;
		endcase
	endfunction

	// reference model of the decode rules
	task automatic predict(input instrWord w, input logic v);
		opcodeField opc;
		funct3Field f3;
		funct7Field f7;
		regAddr rs2;
		logic bad;
		opc = w[6:0];
		f3 = w[14:12];
		f7 = w[31:25];
		rs2 = w[24:20];
		bad = 1'b0;
		expInstr = w;
		clearExpected();
		if (v)
		begin
			expDecodeValid = 1'b1;
			case (opc)
				`OPC_LOAD:
				begin
					expAluSrcB = 1'b1;
					expRegWrite = 1'b1;
					expMemRead = 1'b1;
					expRegSrc = `REGSRC_MEM;
				end
				`OPC_STORE:
				begin
					expAluSrcB = 1'b1;
					expMemWrite = 1'b1;
				end
				`OPC_OPIMM:
				begin
					expAluSrcB = 1'b1;
					expRegWrite = 1'b1;
					expAluControl = baseAluOp(f3, f7 == `FUNCT7_SUB, 1'b0);
				end
				`OPC_RTYPE:
				begin
					expRegWrite = 1'b1;
					if (f7 == `FUNCT7_MULDIV)
						expAluControl = `OPMUL + aluOp'(f3); // mul .. remu in funct3 order
					else if (f7 == `FUNCT7_ZERO || f7 == `FUNCT7_SUB)
						expAluControl = baseAluOp(f3, f7 == `FUNCT7_SUB, 1'b1);
					else
						bad = 1'b1;
				end
				`OPC_AUIPC:
				begin
					expAluSrcA = 1'b1;
					expAluSrcB = 1'b1;
					expRegWrite = 1'b1;
				end
				`OPC_LUI:
				begin
					expAluSrcB = 1'b1;
					expRegWrite = 1'b1;
					expAluControl = `OPLUI;
				end
				`OPC_BRANCH: expPcSource = `PC_BRANCH;
				`OPC_JALR:
				begin
					expRegWrite = 1'b1;
					expRegSrc = `REGSRC_PC4;
					expPcSource = `PC_JALR;
				end
				`OPC_JAL:
				begin
					expRegWrite = 1'b1;
					expRegSrc = `REGSRC_PC4;
					expPcSource = `PC_JAL;
				end
				`OPC_SYSTEM:
				begin
					if (f3 == 3'd0 && rs2 == `RS2_ECALL)
					begin
						expCauseWrite = 1'b1;
						expCauseData = `CAUSE_ECALL;
						expEpcWrite = 1'b1;
						expCsrKind = `CSRKIND_EXC;
						expPcSource = `PC_VECTOR;
					end
					else if (f3 == 3'd0 && rs2 == `RS2_URET)
					begin
						expCsrKind = `CSRKIND_URET;
						expPcSource = `PC_VECTOR;
					end
					else if (f3 == 3'd0 || f3 == 3'd4)
						bad = 1'b1;
					else
					begin
						expRegWrite = 1'b1;
						expRegSrc = `REGSRC_CSR;
						expCsrWrite = 1'b1;
						expCsrKind = `CSRKIND_CSR;
						expCsrSource = f3[2] ? f3 - 3'd2 : f3 - 3'd1; // forms 0 to 5
					end
				end
				default: bad = 1'b1;
			endcase
			if (bad)
			begin
				clearExpected();
				expDecodeValid = 1'b1;
				expAluControl = `OPNULL;
				expCsrWrite = 1'b1;
				expCsrSource = `CSRSRC_INSTR;
				expCauseWrite = 1'b1;
				expCauseData = `CAUSE_ILLEGAL;
				expEpcWrite = 1'b1;
				expCsrKind = `CSRKIND_EXC;
				expPcSource = `PC_VECTOR;
			end
		end
	endtask

	// check the set from the last edge, then drive the next word
	task automatic step(input instrWord w, input logic v);
		@(negedge iCLK);
		checkOutputs();
		instr = w;
		instrValid = v;
		predict(w, v);
	endtask

	function automatic opcodeField knownOpcode(input int idx);
		case (idx)
			0: return `OPC_LOAD;
			1: return `OPC_STORE;
			2: return `OPC_OPIMM;
			3: return `OPC_RTYPE;
			4: return `OPC_AUIPC;
			5: return `OPC_LUI;
			6: return `OPC_BRANCH;
			7: return `OPC_JALR;
			8: return `OPC_JAL;
			default: return `OPC_SYSTEM;
		endcase
	endfunction

	function automatic logic isKnownOpcode(input opcodeField opc);
		for (int i = 0; i < 10; i++)
			if (knownOpcode(i) == opc)
				return 1'b1;
		return 1'b0;
	endfunction

	// random upper fields around a fixed opcode
	function automatic instrWord withOpcode(input opcodeField opc);
		logic [31:0] r;
		r = $urandom();
		return {r[31:7], opc};
	endfunction

	// random rs1, rs2 and rd
	function automatic instrWord withFunct(input funct7Field f7, input funct3Field f3,
		input opcodeField opc);
		logic [31:0] r;
		r = $urandom();
		return {f7, r[24:15], f3, r[11:7], opc};
	endfunction

	task automatic resetDut();
		reset = 1'b1;
		instr = 32'hffffffff; // valid trap word, reset must still win
		instrValid = 1'b1;
		predict('0, 1'b0);
		repeat (16) @(posedge iCLK);
		@(negedge iCLK);
		checkOutputs(); // reset values
		reset = 1'b0;
		instr = '0;
		instrValid = 1'b0;
	endtask

	task automatic testIdle();
		repeat (4) step('0, 1'b0);
		step(withOpcode(`OPC_LOAD), 1'b1);
		step(withOpcode(`OPC_STORE), 1'b0); // word ignored while idle
		step(withOpcode(`OPC_JAL), 1'b0);
	endtask

	task automatic testArith();
		instrWord w;
		for (int rep = 0; rep < 2; rep++)
			for (int f = 0; f < 8; f++)
			begin
				step(withFunct(`FUNCT7_ZERO, 3'(f), `OPC_RTYPE), 1'b1);
				step(withFunct(`FUNCT7_SUB, 3'(f), `OPC_RTYPE), 1'b1);
				step(withFunct(`FUNCT7_MULDIV, 3'(f), `OPC_RTYPE), 1'b1);
				step('0, 1'b0); // decodeValid must drop after one cycle
				w = withOpcode(`OPC_OPIMM);
				w[14:12] = 3'(f);
				step(w, 1'b1);
				step(withFunct(`FUNCT7_SUB, 3'(f), `OPC_OPIMM), 1'b1); // srai shape
				step('0, 1'b0);
			end
	endtask

	task automatic testOthers();
		for (int rep = 0; rep < 4; rep++)
		begin
			step(withOpcode(`OPC_LOAD), 1'b1);
			step(withOpcode(`OPC_STORE), 1'b1);
			step(withOpcode(`OPC_AUIPC), 1'b1);
			step(withOpcode(`OPC_LUI), 1'b1);
			step(withOpcode(`OPC_BRANCH), 1'b1);
			step(withOpcode(`OPC_JAL), 1'b1);
			step(withOpcode(`OPC_JALR), 1'b1);
			step('0, 1'b0);
		end
	endtask

	task automatic testSystem();
		instrWord w;
		for (int rep = 0; rep < 3; rep++)
		begin
			for (int f = 1; f < 8; f++)
				if (f != 4)
				begin
					w = withOpcode(`OPC_SYSTEM); // random csr, rs1 or zimm, rd
					w[14:12] = 3'(f);
					step(w, 1'b1);
				end
			step({7'd0, `RS2_ECALL, 5'd0, 3'd0, 5'd0, `OPC_SYSTEM}, 1'b1);
			step({7'd0, `RS2_URET, 5'd0, 3'd0, 5'd0, `OPC_SYSTEM}, 1'b1);
			step('0, 1'b0);
		end
	endtask

	task automatic testIllegal();
		logic [31:0] r;
		opcodeField opc;
		funct7Field f7;
		instrWord w;
		for (int rep = 0; rep < 16; rep++)
		begin
			r = $urandom();
			opc = r[6:0];
			if (isKnownOpcode(opc))
				opc = 7'h7f;
			step({r[31:7], opc}, 1'b1);
			f7 = r[13:7];
			if (f7 == `FUNCT7_ZERO || f7 == `FUNCT7_SUB || f7 == `FUNCT7_MULDIV)
				f7 = 7'h7f;
			step(withFunct(f7, r[16:14], `OPC_RTYPE), 1'b1);
			w = withOpcode(`OPC_SYSTEM);
			w[14:12] = 3'd0;
			if (w[24:20] == `RS2_ECALL || w[24:20] == `RS2_URET)
				w[24:20] = 5'd1;
			step(w, 1'b1);
			w[14:12] = 3'd4; // reserved funct3
			step(w, 1'b1);
			step('0, 1'b0);
		end
	endtask

	task automatic testMixed();
		logic [31:0] r;
		int idx;
		for (int n = 0; n < 200; n++)
		begin
			r = $urandom();
			idx = int'(r[7:4]) % 11;
			if (idx == 10)
				step($urandom(), r[1:0] != 2'b00);
			else
				step(withOpcode(knownOpcode(idx)), r[1:0] != 2'b00);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		void'($urandom(32'h993ba166));
		resetDut();
		testIdle();
		testArith();
		testOthers();
		testSystem();
		testIllegal();
		testMixed();
		step('0, 1'b0); // checks the last word
		step('0, 1'b0);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+logic
logic/decodeTypes.sv
logic/aluOpDecoder.sv
logic/systemDecoder.sv
logic/opcodeDecoder.sv
logic/controlUnit.sv
tests/controlUnit_assert.sv
tests/controlUnitTb.sv

//--- run.sh
#!/bin/sh
# compile the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module controlUnitTb -o simControlUnit \
	&& ./obj_dir/simControlUnit \
	|| exit 1
